/* hdl/i2c_slave_pkg.sv */
`default_nettype none

package i2c_slave_pkg;

	// widths that carry a meaning on the bus and in the memory
	typedef logic [7:0]  byte_t;
	typedef logic [10:0] mem_addr_t;
	typedef logic [3:0]  dev_code_t;
	typedef logic [2:0]  addr_pins_t;

	// single-cycle event pulses from the line sampler, plus the stable sda level
	typedef struct packed {
		logic scl_rise;
		logic scl_fall;
		logic start;
		logic stop;
		logic sda;
	} bus_events_t;

	// pointer load request, data unused on this path
	typedef struct packed {
		logic      valid;
		mem_addr_t addr;
		byte_t     data;
	} mem_write_t;

	// pulses and payload towards the storage array
	typedef struct packed {
		logic      wr_en;
		byte_t     wr_data;
		logic      rd_next;
		logic      ptr_load;
		mem_addr_t ptr_value;
	} mem_ctrl_t;

	typedef enum logic [1:0] {
		tx_release,
		tx_ack,
		tx_byte
	} tx_mode_t;

	typedef enum logic [2:0] {
		st_idle,
		st_dev_addr,
		st_addr_hi,
		st_addr_lo,
		st_write_data,
		st_read_data,
		st_ignore
	} deser_state_t;

endpackage

`default_nettype wire

/* hdl/i2c_line_sampler.sv */
`timescale 1ns/1ps
`default_nettype none

module i2c_line_sampler (
	input  wire                         Clock,
	input  wire                         Reset,
	input  wire                         scl,
	input  wire                         sda,
	output i2c_slave_pkg::bus_events_t  events
);

	import i2c_slave_pkg::*;

	// two-flop synchronizers, idle bus is high
	logic scl_s1;
	logic scl_s2;
	logic sda_s1;
	logic sda_s2;

	// levels seen in the previous cycle
	logic scl_prev;
	logic sda_prev;

	always_ff @(posedge Clock or negedge Reset)
	begin
		if (!Reset)
		begin
			scl_s1   <= 1'b1;
			scl_s2   <= 1'b1;
			sda_s1   <= 1'b1;
			sda_s2   <= 1'b1;
			scl_prev <= 1'b1;
			sda_prev <= 1'b1;
		end
		else
		begin
			scl_s1   <= scl;
			scl_s2   <= scl_s1;
			sda_s1   <= sda;
			sda_s2   <= sda_s1;
			scl_prev <= scl_s2;
			sda_prev <= sda_s2;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// event pulses, registered so each lasts exactly one cycle
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge Clock or negedge Reset)
	begin
		if (!Reset)
		begin
			events <= '{default: 1'b0, sda: 1'b1};
		end
		else
		begin
			events.scl_rise <= scl_s2 & ~scl_prev;
			events.scl_fall <= ~scl_s2 & scl_prev;
			// sda moving while scl stays high
			events.start    <= scl_s2 & scl_prev & sda_prev & ~sda_s2;
			events.stop     <= scl_s2 & scl_prev & ~sda_prev & sda_s2;
			events.sda      <= sda_s2;
		end
	end

endmodule

`default_nettype wire

/* hdl/i2c_deserializer.sv */
`timescale 1ns/1ps
`default_nettype none

module i2c_deserializer #(
	parameter i2c_slave_pkg::dev_code_t DEVICE_CODE = 4'b1010
) (
	input  wire                         Clock,
	input  wire                         Reset,
	input  wire i2c_slave_pkg::bus_events_t events,
	input  wire i2c_slave_pkg::addr_pins_t  addr_pins,
	output i2c_slave_pkg::tx_mode_t     tx_mode,
	output i2c_slave_pkg::mem_ctrl_t    mem_ctrl
);

	import i2c_slave_pkg::*;

	deser_state_t state;

	// rising edges seen in this byte, 9 once the ack bit is sampled
	logic [3:0] bit_cnt;
	byte_t      shift;
	byte_t      addr_hi;
	logic       addr_match;
	mem_write_t ptr_req;

	assign addr_match = (shift[7:1] == {DEVICE_CODE, addr_pins});

	// second address byte complete, load the pointer
	always_comb
	begin
		ptr_req.valid = (state == st_addr_lo) && events.scl_fall && (bit_cnt == 4'd8);
		ptr_req.addr  = {addr_hi, shift[7:5]};
		ptr_req.data  = shift;
	end

	// payload shifting, no reset needed
	always_ff @(posedge Clock)
	begin
		if (events.scl_rise && (bit_cnt < 4'd8))
			shift <= {shift[6:0], events.sda};
		if ((state == st_addr_hi) && events.scl_fall && (bit_cnt == 4'd8))
			addr_hi <= shift;
	end

	////////////////////////////////////////////////////////////////////////////
	// protocol FSM
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge Clock or negedge Reset)
	begin
		if (!Reset)
		begin
			state    <= st_idle;
			bit_cnt  <= '0;
			tx_mode  <= tx_release;
			mem_ctrl <= '0;
		end
		else
		begin
			mem_ctrl.wr_en    <= 1'b0;
			mem_ctrl.rd_next  <= 1'b0;
			mem_ctrl.ptr_load <= 1'b0;

			if (ptr_req.valid)
			begin
				mem_ctrl.ptr_load  <= 1'b1;
				mem_ctrl.ptr_value <= ptr_req.addr;
			end

			if (events.stop)
			begin
				state   <= st_idle;
				tx_mode <= tx_release;
			end
			else if (events.start)
			begin
				state   <= st_dev_addr;
				bit_cnt <= '0;
				tx_mode <= tx_release;
			end
			else if ((state != st_idle) && (state != st_ignore))
			begin
				if (events.scl_rise)
				begin
					if (bit_cnt != 4'd9)
						bit_cnt <= bit_cnt + 4'd1;
					// master ack bit of a read byte
					// pointer moves on either way so a later read continues
					if ((state == st_read_data) && (bit_cnt == 4'd8))
					begin
						mem_ctrl.rd_next <= 1'b1;
						if (events.sda)
							state <= st_ignore;
					end
				end
				else if (events.scl_fall && (bit_cnt == 4'd8))
				begin
					// eighth bit done, ack phase begins
					case (state)
						st_dev_addr:
						begin
							if (addr_match)
								tx_mode <= tx_ack;
							else
								state <= st_ignore;
						end
						st_addr_hi, st_addr_lo:
							tx_mode <= tx_ack;
						st_write_data:
						begin
							tx_mode          <= tx_ack;
							mem_ctrl.wr_en   <= 1'b1;
							mem_ctrl.wr_data <= shift;
						end
						default:
							tx_mode <= tx_release;
					endcase
				end
				else if (events.scl_fall && (bit_cnt == 4'd9))
				begin
					// ack phase over, next byte starts
					bit_cnt <= '0;
					case (state)
						st_dev_addr:
						begin
							// r/w bit, 1 means read
							if (shift[0])
							begin
								state   <= st_read_data;
								tx_mode <= tx_byte;
							end
							else
							begin
								state   <= st_addr_hi;
								tx_mode <= tx_release;
							end
						end
						st_addr_hi:
						begin
							state   <= st_addr_lo;
							tx_mode <= tx_release;
						end
						st_addr_lo:
						begin
							state   <= st_write_data;
							tx_mode <= tx_release;
						end
						st_read_data:
							tx_mode <= tx_byte;
						default:
							tx_mode <= tx_release;
					endcase
				end
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/i2c_serializer.sv */
`timescale 1ns/1ps
`default_nettype none

module i2c_serializer (
	input  wire                             Clock,
	input  wire                             Reset,
	input  wire i2c_slave_pkg::bus_events_t events,
	input  wire i2c_slave_pkg::tx_mode_t    tx_mode,
	input  wire i2c_slave_pkg::byte_t       rd_data,
	output logic                            sda_oe
);

	import i2c_slave_pkg::*;

	tx_mode_t   mode_q;
	byte_t      shift;
	logic [3:0] bit_cnt;
	logic       load;

	// entering tx_byte marks the first scl_fall of a read byte
	assign load = (tx_mode == tx_byte) && (mode_q != tx_byte);

	always_ff @(posedge Clock)
	begin
		if (load)
			shift <= rd_data;
		else if ((tx_mode == tx_byte) && events.scl_fall)
			shift <= {shift[6:0], 1'b0};
	end

	always_ff @(posedge Clock or negedge Reset)
	begin
		if (!Reset)
		begin
			mode_q  <= tx_release;
			bit_cnt <= '0;
			sda_oe  <= 1'b0;
		end
		else
		begin
			mode_q <= tx_mode;
			case (tx_mode)
				tx_ack:
					sda_oe <= 1'b1;
				tx_byte:
				begin
					if (load)
					begin
						// msb goes out first, pull low for a zero
						bit_cnt <= '0;
						sda_oe  <= ~rd_data[7];
					end
					else if (events.scl_fall && (bit_cnt < 4'd8))
					begin
						bit_cnt <= bit_cnt + 4'd1;
						// after bit 7, let go for the master ack
						if (bit_cnt == 4'd7)
							sda_oe <= 1'b0;
						else
							sda_oe <= ~shift[6];
					end
				end
				default:
					sda_oe <= 1'b0;
			endcase
		end
	end

endmodule

`default_nettype wire

/* hdl/eeprom_array.sv */
`timescale 1ns/1ps
`default_nettype none

module eeprom_array (
	input  wire                           Clock,
	input  wire                           Reset,
	input  wire i2c_slave_pkg::mem_ctrl_t mem_ctrl,
	output i2c_slave_pkg::byte_t          rd_data
);

	import i2c_slave_pkg::*;

	localparam int unsigned DEPTH = 1 << $bits(mem_addr_t);

	byte_t     mem [DEPTH];
	mem_addr_t ptr;

	////////////////////////////////////////////////////////////////////////////
	// address pointer
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge Clock or negedge Reset)
	begin
		if (!Reset)
		begin
			ptr <= '0;
		end
		else if (mem_ctrl.ptr_load)
		begin
			ptr <= mem_ctrl.ptr_value;
		end
		else if (mem_ctrl.wr_en || mem_ctrl.rd_next)
		begin
			// wraps from 2047 to 0
			ptr <= ptr + 1'b1;
		end
	end

	// write at the pointer before it moves
	always_ff @(posedge Clock)
	begin
		if (mem_ctrl.wr_en)
			mem[ptr] <= mem_ctrl.wr_data;
	end

	assign rd_data = mem[ptr];

endmodule

`default_nettype wire

/* hdl/i2c_eeprom_top.sv */
`timescale 1ns/1ps
`default_nettype none

module i2c_eeprom_top #(
	parameter i2c_slave_pkg::dev_code_t DEVICE_CODE = 4'b1010
) (
	input  wire                            Clock,
	input  wire                            Reset,
	input  wire                            scl,
	input  wire                            sda_in,
	output logic                           sda_oe,
	input  wire i2c_slave_pkg::addr_pins_t addr_pins
);

	import i2c_slave_pkg::*;

	bus_events_t events;
	tx_mode_t    tx_mode;
	mem_ctrl_t   mem_ctrl;
	byte_t       rd_data;

	i2c_line_sampler i_i2c_line_sampler (
		.Clock  (Clock),
		.Reset  (Reset),
		.scl    (scl),
		.sda    (sda_in),
		.events (events)
	);

	i2c_deserializer #(
		.DEVICE_CODE (DEVICE_CODE)
	) i_i2c_deserializer (
		.Clock     (Clock),
		.Reset     (Reset),
		.events    (events),
		.addr_pins (addr_pins),
		.tx_mode   (tx_mode),
		.mem_ctrl  (mem_ctrl)
	);

	i2c_serializer i_i2c_serializer (
		.Clock   (Clock),
		.Reset   (Reset),
		.events  (events),
		.tx_mode (tx_mode),
		.rd_data (rd_data),
		.sda_oe  (sda_oe)
	);

	eeprom_array i_eeprom_array (
		.Clock    (Clock),
		.Reset    (Reset),
		.mem_ctrl (mem_ctrl),
		.rd_data  (rd_data)
	);

endmodule

`default_nettype wire

/* tests/i2c_eeprom_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module i2c_eeprom_sva (
	input wire                           Clock,
	input wire                           Reset,
	input wire                           scl,
	input wire                           sda_oe,
	input wire i2c_slave_pkg::mem_ctrl_t mem_ctrl
);

	// slave moves sda only while scl is low
	oe_stable_scl_high: assert property (@(posedge Clock) disable iff (!Reset)
		(scl && $past(scl)) |-> $stable(sda_oe))
		else $error("sda_oe changed while scl was high");

	wr_en_pulse: assert property (@(posedge Clock) disable iff (!Reset)
		mem_ctrl.wr_en |=> !mem_ctrl.wr_en)
		else $error("wr_en lasted more than one cycle");

	rd_next_pulse: assert property (@(posedge Clock) disable iff (!Reset)
		mem_ctrl.rd_next |=> !mem_ctrl.rd_next)
		else $error("rd_next lasted more than one cycle");

	ptr_load_pulse: assert property (@(posedge Clock) disable iff (!Reset)
		mem_ctrl.ptr_load |=> !mem_ctrl.ptr_load)
		else $error("ptr_load lasted more than one cycle");

	oe_after_reset: assert property (@(posedge Clock) !Reset |=> !sda_oe)
		else $error("sda_oe driven in the cycle after reset");

endmodule

bind i2c_eeprom_top i2c_eeprom_sva i_i2c_eeprom_sva (
	.Clock    (Clock),
	.Reset    (Reset),
	.scl      (scl),
	.sda_oe   (sda_oe),
	.mem_ctrl (mem_ctrl)
);

`default_nettype wire

/* tests/tb_i2c_eeprom.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_i2c_eeprom;

	import i2c_slave_pkg::*;

	localparam dev_code_t DEVICE_CODE = 4'b1010;
	// bytes on the bus over all tests, each 9 bits of 32 cycles
	localparam int BYTES_SENT = 94;
	localparam int TIMEOUT_CYCLES = BYTES_SENT * 9 * 32 + 4000;

	logic        Clock;
	logic        Reset;
	logic        scl;
	logic        master_low;
	wire         sda_in;
	wire         sda_oe;
	addr_pins_t  pins;
	addr_pins_t  old_pins;

	logic [31:0] rng_state;
	byte_t       ref_mem [2048];
	byte_t       wbuf [8];
	logic        oe_seen;
	mem_addr_t   single_addr;
	mem_addr_t   burst_addr;

	// open-drain bus, either side can pull low
	assign sda_in = (master_low || sda_oe) ? 1'b0 : 1'b1;

	i2c_eeprom_top #(
		.DEVICE_CODE (DEVICE_CODE)
	) i_i2c_eeprom_top (
		.Clock     (Clock),
		.Reset     (Reset),
		.scl       (scl),
		.sda_in    (sda_in),
		.sda_oe    (sda_oe),
		.addr_pins (pins)
	);

	initial
	begin
		Clock = 1'b0;
		forever #4 Clock = ~Clock;
	end

	// any slave drive at all since reset
	always @(posedge Clock or negedge Reset)
	begin
		if (!Reset)
			oe_seen <= 1'b0;
		else if (sda_oe)
			oe_seen <= 1'b1;
	end

	initial
	begin
		repeat (TIMEOUT_CYCLES) @(posedge Clock);
		$display("watchdog expired after %0d cycles", TIMEOUT_CYCLES);
		$display("=== FAIL ===");
		$fatal(1, "simulation timed out");
	end

	////////////////////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////////////////////
	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_rand();
		rng_state = xorshift(rng_state);
		return rng_state;
	endfunction

	function automatic byte_t dev_byte(input dev_code_t code, input addr_pins_t p, input logic rd);
		return {code, p, rd};
	endfunction

	task automatic check_value(input string name, input byte_t got, input byte_t exp);
		assert (got === exp)
		else
		begin
			$display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
			$display("=== FAIL ===");
			$fatal(1, "check on %s failed", name);
		end
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge Clock);
		#1;
	endtask

	task automatic fill_wbuf();
		for (int i = 0; i < 8; i++)
			wbuf[i] = byte_t'(next_rand());
	endtask

	////////////////////////////////////////////////////////////////////////////
	// I2C master, every SCL phase 16 cycles
	////////////////////////////////////////////////////////////////////////////
	task automatic start_condition();
		wait_cycles(8);
		master_low = 1'b0;
		wait_cycles(8);
		scl = 1'b1;
		wait_cycles(16);
		// sda falls while scl is high
		master_low = 1'b1;
		wait_cycles(16);
		scl = 1'b0;
	endtask

	task automatic stop_condition();
		scl = 1'b0;
		wait_cycles(8);
		master_low = 1'b1;
		wait_cycles(8);
		scl = 1'b1;
		wait_cycles(16);
		master_low = 1'b0;
		wait_cycles(16);
	endtask

	task automatic write_byte(input byte_t b, output logic ack);
		for (int i = 7; i >= 0; i--)
		begin
			wait_cycles(8);
			master_low = ~b[i];
			wait_cycles(8);
			scl = 1'b1;
			wait_cycles(16);
			scl = 1'b0;
		end
		// ninth bit left to the slave
		wait_cycles(8);
		master_low = 1'b0;
		wait_cycles(8);
		scl = 1'b1;
		wait_cycles(15);
		ack = sda_in;
		wait_cycles(1);
		scl = 1'b0;
	endtask

	task automatic read_byte(input logic master_ack, output byte_t b);
		for (int i = 7; i >= 0; i--)
		begin
			wait_cycles(8);
			master_low = 1'b0;
			wait_cycles(8);
			scl = 1'b1;
			wait_cycles(15);
			b[i] = sda_in;
			wait_cycles(1);
			scl = 1'b0;
		end
		// low for ack, released for nack
		wait_cycles(8);
		master_low = master_ack;
		wait_cycles(8);
		scl = 1'b1;
		wait_cycles(16);
		scl = 1'b0;
	endtask

	// either every byte is acked or none is
	task automatic write_burst(input byte_t dev, input mem_addr_t addr, input int n,
		input logic acked);
		logic  ack;
		byte_t exp_ack;
		exp_ack = acked ? 8'h00 : 8'h01;
		start_condition();
		write_byte(dev, ack);
		check_value("dev_ack", byte_t'(ack), exp_ack);
		write_byte(addr[10:3], ack);
		check_value("addr_hi_ack", byte_t'(ack), exp_ack);
		write_byte({addr[2:0], 5'b0}, ack);
		check_value("addr_lo_ack", byte_t'(ack), exp_ack);
		for (int i = 0; i < n; i++)
		begin
			write_byte(wbuf[i], ack);
			check_value("data_ack", byte_t'(ack), exp_ack);
			if (acked)
				ref_mem[addr + mem_addr_t'(i)] = wbuf[i];
		end
		stop_condition();
	endtask

	// read from the current pointer, nack on the last byte
	task automatic read_current(input mem_addr_t addr, input int n);
		logic  ack;
		byte_t b;
		start_condition();
		write_byte(dev_byte(DEVICE_CODE, pins, 1'b1), ack);
		check_value("dev_ack", byte_t'(ack), 8'h00);
		for (int i = 0; i < n; i++)
		begin
			read_byte(i != n - 1, b);
			check_value("rd_byte", b, ref_mem[addr + mem_addr_t'(i)]);
		end
		stop_condition();
	endtask

	// set the pointer, then repeated start into a read
	task automatic read_from(input mem_addr_t addr, input int n);
		logic ack;
		start_condition();
		write_byte(dev_byte(DEVICE_CODE, pins, 1'b0), ack);
		check_value("dev_ack", byte_t'(ack), 8'h00);
		write_byte(addr[10:3], ack);
		check_value("addr_hi_ack", byte_t'(ack), 8'h00);
		write_byte({addr[2:0], 5'b0}, ack);
		check_value("addr_lo_ack", byte_t'(ack), 8'h00);
		read_current(addr, n);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////////////////////
	initial
	begin
		Reset = 1'b0;
		scl = 1'b1;
		master_low = 1'b0;
		pins = 3'b101;
		old_pins = 3'b101;
		rng_state = 32'd37;
		wait_cycles(8);
		Reset = 1'b1;

		// stop on an idle bus
		wait_cycles(4);
		stop_condition();
		wait_cycles(16);
		check_value("sda_oe", byte_t'(oe_seen), 8'h00);

		// single write, random read
		single_addr = mem_addr_t'(next_rand());
		wbuf[0] = byte_t'(next_rand());
		write_burst(dev_byte(DEVICE_CODE, pins, 1'b0), single_addr, 1, 1'b1);
		read_from(single_addr, 1);

		// bursts of 8, the second wraps past 2047
		fill_wbuf();
		burst_addr = mem_addr_t'(next_rand());
		write_burst(dev_byte(DEVICE_CODE, pins, 1'b0), burst_addr, 8, 1'b1);
		read_from(burst_addr, 8);
		fill_wbuf();
		write_burst(dev_byte(DEVICE_CODE, pins, 1'b0), 11'd2044, 8, 1'b1);
		read_from(11'd2044, 8);

		// wrong code, then wrong pins
		wbuf[0] = ~ref_mem[single_addr];
		write_burst(dev_byte(4'b1011, pins, 1'b0), single_addr, 1, 1'b0);
		write_burst(dev_byte(DEVICE_CODE, pins ^ 3'b001, 1'b0), single_addr, 1, 1'b0);
		read_from(single_addr, 1);

		// new pin strapping
		old_pins = pins;
		pins = 3'b010;
		wait_cycles(16);
		wbuf[0] = ~ref_mem[single_addr];
		write_burst(dev_byte(DEVICE_CODE, old_pins, 1'b0), single_addr, 1, 1'b0);
		write_burst(dev_byte(DEVICE_CODE, pins, 1'b0), single_addr, 1, 1'b1);
		read_from(single_addr, 1);

		// nack ends a read, the next read picks up after it
		read_from(burst_addr, 3);
		read_current(burst_addr + 11'd3, 5);

		$display("=== PASS ===");
		$finish;
	end

endmodule

`default_nettype wire

/* build.f */
hdl/i2c_slave_pkg.sv
hdl/i2c_line_sampler.sv
hdl/i2c_deserializer.sv
hdl/i2c_serializer.sv
hdl/eeprom_array.sv
hdl/i2c_eeprom_top.sv
tests/i2c_eeprom_sva.sv
tests/tb_i2c_eeprom.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       ?= tb_i2c_eeprom
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
